// File: tb/sram_subsystem_input.txt
# op (w write, r read), address (hex), write data or expected read data (hex),
# idle cycles after the request is taken (decimal, -1 picks 0 to 3 at random)
w 00010 1234 2
w 00011 abcd 1
w 0a5c3 5a5a 0
w fffff 8001 3
w 12345 0f0f -1
w 00012 beef 5
r 00010 1234 5
r 00011 abcd 4
r 0a5c3 5a5a -1
r fffff 8001 0
r 12345 0f0f 1
r 00012 beef 6
# never written, power-up fill of the model
r 00020 c385 4
r 30000 c3a6 -1
r abcde 7f71 6
# back-to-back mix, fills the queue
w 00100 1111 0
w 00101 2222 0
r 00100 1111 0
w 00102 3333 0
r 00101 2222 0
r 00102 3333 0
w 00100 4444 0
r 00100 4444 6
# reads only at full rate
r 00010 1234 0
r 0a5c3 5a5a 0
r 00101 2222 0
r 00020 c385 0
r 00102 3333 0
r 12345 0f0f 5
# overwrite and read straight back
w 0a5c3 0001 0
r 0a5c3 0001 0
w 0a5c3 ffff -1
r 0a5c3 ffff 4
r fffff 8001 -1
w 00011 5555 0
r 00011 5555 0
r 00012 beef 8

// File: sram_subsystem.f
src/sram_bus_pkg.sv
src/sram_ctrl_pkg.sv
src/sram_req_if.sv
src/sram_req_queue.sv
src/sram_controller.sv
src/sram_subsystem.sv
tb/sram_model.sv
tb/sram_subsystem_tb.sv

// File: tb/sram_subsystem_tb.sv
module sram_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int addr_bits = sram_bus_pkg::default_addr_bits;
  localparam int data_bits = sram_bus_pkg::default_data_bits;
  localparam int queue_depth = 4;
  localparam int clk_half_ns = 4;
  localparam int drive_delay_ns = 1;
  localparam string input_file = "tb/sram_subsystem_input.txt";

  logic                 clk;
  logic                 reset;
  logic                 req;
  logic                 write_enable;
  logic [addr_bits-1:0] addr;
  logic [data_bits-1:0] write_data;
  logic                 ready;
  logic                 rd_valid;
  logic [data_bits-1:0] read_data;
  logic [addr_bits-1:0] addr_bus;
  wire  [data_bits-1:0] data_bus_io;
  logic                 we_n;
  logic                 oe_n;
  logic                 ce_n;
  logic                 bus_conflict;

  // request table, one entry per file line
  sram_ctrl_pkg::sram_op_e op_list[$];
  logic [addr_bits-1:0]    addr_list[$];
  logic [data_bits-1:0]    data_list[$];
  int                      gap_list[$];

  // scoreboard, read results in request order
  logic [data_bits-1:0] expected_q[$];
  int                   accept_cycle_q[$];
  bit                   isolated_q[$];

  int seed;
  int cycle_count = 0;
  int cycle_limit = 0;
  int reads_total = 0;
  int reads_seen = 0;
  int isolated_checked = 0;
  bit saw_full = 1'b0;
  bit was_in_reset = 1'b0;

  // reference queue occupancy
  int queued = 0;
  bit access_busy = 1'b0;
  bit model_take;
  bit accept;
  int started;
  bit isolated;

  sram_subsystem #(
    .addr_bits   (addr_bits),
    .data_bits   (data_bits),
    .queue_depth (queue_depth)
  ) uut (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .write_enable (write_enable),
    .addr         (addr),
    .write_data   (write_data),
    .ready        (ready),
    .rd_valid     (rd_valid),
    .read_data    (read_data),
    .addr_bus     (addr_bus),
    .data_bus_io  (data_bus_io),
    .we_n         (we_n),
    .oe_n         (oe_n),
    .ce_n         (ce_n)
  );

  sram_model #(
    .addr_bits (addr_bits),
    .data_bits (data_bits)
  ) chip (
    .addr_bus     (addr_bus),
    .data_bus_io  (data_bus_io),
    .we_n         (we_n),
    .oe_n         (oe_n),
    .ce_n         (ce_n),
    .bus_conflict (bus_conflict)
  );

  always #clk_half_ns clk = ~clk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_data(input string name, input logic [data_bits-1:0] actual,
                              input logic [data_bits-1:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected 0x%h, got 0x%h", name, expected, actual));
    end
  endtask

  task automatic compare_strobe(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: expected 0x%h, got 0x%h", name, expected, actual));
    end
  endtask

  // columns are op, address, data, gap; lines starting with # are notes
  task automatic load_requests();
    int fd;
    int n;
    int g;
    string tok;
    string rest;
    logic [addr_bits-1:0] a;
    logic [data_bits-1:0] d;
    fd = $fopen(input_file, "r");
    if (fd == 0) begin
      stop_with_failure("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n == 1) begin
          if (tok.substr(0, 0) == "#") begin
            n = $fgets(rest, fd);
          end else if ((tok != "w" && tok != "r") || $fscanf(fd, "%h %h %d", a, d, g) != 3) begin
            stop_with_failure({"malformed stimulus line starting with ", tok});
          end else begin
            op_list.push_back(tok == "w" ? sram_ctrl_pkg::op_write : sram_ctrl_pkg::op_read);
            addr_list.push_back(a);
            data_list.push_back(d);
            gap_list.push_back(g);
            if (tok == "r") begin
              reads_total++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // checks on every rising edge, all values sampled before the edge updates
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      stop_with_failure($sformatf("run timed out after %0d cycles, %0d of %0d reads returned",
                                  cycle_count, reads_seen, reads_total));
    end
    compare_strobe("ce_n", ce_n, 1'b0);
    // idle pins during reset and the cycle after it
    if (reset || was_in_reset) begin
      compare_strobe("we_n", we_n, 1'b1);
      compare_strobe("oe_n", oe_n, 1'b1);
      compare_strobe("rd_valid", rd_valid, 1'b0);
      compare_strobe("ready", ready, 1'b1);
    end
    was_in_reset = reset;
    if (!we_n && !oe_n) begin
      stop_with_failure("we_n and oe_n were low at the same time");
    end
    // ready only falls with queue_depth entries waiting
    compare_strobe("ready", ready, queued != queue_depth);
    if (ready === 1'b0) begin
      saw_full = 1'b1;
    end
    // controller pops in idle when an entry waits, then spends one clock on the access
    model_take = !access_busy && (queued > 0);
    accept = !reset && req && (queued != queue_depth);
    if (accept && !write_enable) begin
      accept_cycle_q.push_back(cycle_count);
      isolated_q.push_back(queued == 0);
    end
    if (reset) begin
      queued = 0;
      access_busy = 1'b0;
    end else begin
      queued = queued + int'(accept) - int'(model_take);
      access_busy = model_take;
    end
    if (rd_valid === 1'b1) begin
      if (expected_q.size() == 0 || accept_cycle_q.size() == 0) begin
        stop_with_failure("rd_valid pulsed with no read outstanding");
      end
      compare_data("read_data", read_data, expected_q.pop_front());
      started = accept_cycle_q.pop_front();
      isolated = isolated_q.pop_front();
      // rd_valid rises 3 edges after acceptance, seen here one edge later
      if (isolated) begin
        if (cycle_count - started != 4) begin
          stop_with_failure($sformatf("isolated read came %0d cycles after acceptance, not 3",
                                      cycle_count - started - 1));
        end
        isolated_checked++;
      end
      reads_seen++;
    end
  end

  always @(posedge bus_conflict) begin
    stop_with_failure("the SRAM model reported a bus conflict");
  end

  initial begin
    int i;
    int gap;
    clk = 1'b0;
    reset = 1'b0;
    req = 1'b0;
    write_enable = 1'b0;
    addr = '0;
    write_data = '0;
    seed = 5;
    load_requests();
    cycle_limit = 20 * op_list.size() + 50;
    // reset spans the first two rising edges
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #drive_delay_ns reset = 1'b0;
    for (i = 0; i < op_list.size(); i++) begin
      req = 1'b1;
      write_enable = (op_list[i] == sram_ctrl_pkg::op_write);
      addr = addr_list[i];
      write_data = write_enable ? data_list[i] : '0;
      // ready seen after an edge holds until the next one
      while (ready !== 1'b1) begin
        @(posedge clk);
        #drive_delay_ns;
      end
      @(posedge clk);
      #drive_delay_ns;
      if (op_list[i] == sram_ctrl_pkg::op_read) begin
        expected_q.push_back(data_list[i]);
      end
      req = 1'b0;
      gap = gap_list[i];
      if (gap < 0) begin
        gap = $random(seed) & 3;
      end
      repeat (gap) begin
        @(posedge clk);
        #drive_delay_ns;
      end
    end
    wait (reads_seen == reads_total);
    // let a trailing write finish its strobe
    repeat (4) @(posedge clk);
    if (!saw_full) begin
      stop_with_failure("ready never went low during the back-to-back requests");
    end else if (isolated_checked == 0) begin
      stop_with_failure("no read was issued to an idle queue, latency went unchecked");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: tb/sram_model.sv
module sram_model #(
  parameter int addr_bits = sram_bus_pkg::default_addr_bits,
  parameter int data_bits = sram_bus_pkg::default_data_bits
) (
  input  logic [addr_bits-1:0] addr_bus,
  inout  wire  [data_bits-1:0] data_bus_io,
  input  logic                 we_n,
  input  logic                 oe_n,
  input  logic                 ce_n,
  // set once the chip output and the controller fight over the bus
  output logic                 bus_conflict
);
  timeunit 1ns;
  timeprecision 100ps;

  // whole array, one word per address
  logic [data_bits-1:0] mem [0:(2**addr_bits)-1];
  logic [data_bits-1:0] dout;
  logic                 out_en;

  // power-up contents, every address bit folded into the word
  function automatic logic [data_bits-1:0] fill_value(input logic [addr_bits-1:0] a);
    logic [data_bits-1:0] v;
    int b;
    v = data_bits'(16'hc3a5);
    for (b = 0; b < addr_bits; b++) begin
      v[b % data_bits] = v[b % data_bits] ^ a[b];
    end
    return v;
  endfunction

  initial begin
    int i;
    bus_conflict = 1'b0;
    out_en = 1'b0;
    dout = '0;
    for (i = 0; i < 2**addr_bits; i++) begin
      mem[i] = fill_value(addr_bits'(i));
    end
  end

  // chip output, high-z unless a read window is open
  assign data_bus_io = out_en ? dout : {data_bits{1'bz}};

  // data shows up t_output_ns after oe_n falls
  always @(negedge oe_n) begin
    if (!ce_n && we_n) begin
      #(sram_bus_pkg::t_output_ns);
      if (!oe_n) begin
        dout = mem[addr_bus];
        out_en = 1'b1;
      end
    end
  end

  // output floats as soon as oe_n goes back high
  always @(posedge oe_n) begin
    out_en = 1'b0;
  end

  // write lands on the rising edge of we_n
  always @(posedge we_n) begin
    if (!ce_n && !$isunknown(addr_bus)) begin
      mem[addr_bus] = data_bus_io;
    end
  end

  // anything other than our own word on the bus means a second driver
  always @(data_bus_io) begin
    if (out_en && data_bus_io !== dout) begin
      $display("SRAM model: the controller drove data_bus_io while the chip output at %0t",
               $time);
      bus_conflict = 1'b1;
    end
  end

  // write strobe during an open read window
  always @(negedge we_n) begin
    if (!oe_n) begin
      $display("SRAM model: we_n fell while oe_n was low at %0t", $time);
      bus_conflict = 1'b1;
    end
  end

endmodule

// File: src/sram_subsystem.sv
module sram_subsystem #(
  parameter int addr_bits   = sram_bus_pkg::default_addr_bits,
  parameter int data_bits   = sram_bus_pkg::default_data_bits,
  parameter int queue_depth = sram_bus_pkg::default_queue_depth
) (
  input  logic                 clk,
  input  logic                 reset,
  // caller requests
  input  logic                 req,
  input  logic                 write_enable,
  input  logic [addr_bits-1:0] addr,
  input  logic [data_bits-1:0] write_data,
  output logic                 ready,
  // read results, in request order
  output logic                 rd_valid,
  output logic [data_bits-1:0] read_data,
  // SRAM chip pins
  output logic [addr_bits-1:0] addr_bus,
  inout  wire  [data_bits-1:0] data_bus_io,
  output logic                 we_n,
  output logic                 oe_n,
  output logic                 ce_n
);

  // queue head to controller
  sram_req_if #(
    .addr_bits (addr_bits),
    .data_bits (data_bits)
  ) req_head ();

  // buffers caller requests, the only source of back-pressure
  sram_req_queue #(
    .addr_bits   (addr_bits),
    .data_bits   (data_bits),
    .queue_depth (queue_depth)
  ) u_queue (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .write_enable (write_enable),
    .addr         (addr),
    .write_data   (write_data),
    .ready        (ready),
    .q            (req_head.queue_side)
  );

  // two-cycle access FSM, owns every chip pin
  sram_controller #(
    .addr_bits (addr_bits),
    .data_bits (data_bits)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .q           (req_head.ctrl_side),
    .rd_valid    (rd_valid),
    .read_data   (read_data),
    .addr_bus    (addr_bus),
    .data_bus_io (data_bus_io),
    .we_n        (we_n),
    .oe_n        (oe_n),
    .ce_n        (ce_n)
  );

endmodule

// File: src/sram_controller.sv
module sram_controller #(
  parameter int addr_bits = sram_bus_pkg::default_addr_bits,
  parameter int data_bits = sram_bus_pkg::default_data_bits
) (
  input  logic                 clk,
  input  logic                 reset,
  // queued requests
  sram_req_if.ctrl_side        q,
  // read results back to the caller, no back-pressure
  output logic                 rd_valid,
  output logic [data_bits-1:0] read_data,
  // SRAM chip pins
  output logic [addr_bits-1:0] addr_bus,
  inout  wire  [data_bits-1:0] data_bus_io,
  output logic                 we_n,
  output logic                 oe_n,
  output logic                 ce_n
);

  // every access is two clocks, counted from the edge that raises take (E)
  //   E        addr_bus and write data latched, FSM leaves st_idle
  //   E + 0.5  we_n or oe_n goes low
  //   E + 1    FSM back in st_idle, may take the next request
  //   E + 1.5  strobe released, read data captured here
  //   E + 2    next access may start, rd_valid set for a read
  // the strobe sits high for a full clock between two accesses

  sram_ctrl_pkg::ctrl_state_e state;
  sram_ctrl_pkg::ctrl_state_e next_state;

  logic                 take;
  logic [data_bits-1:0] write_data_reg;
  // write data stays on the bus one extra cycle, past the we_n release
  logic                 wr_tail;
  logic                 bus_drive;
  // a read finished its strobe window this cycle
  logic                 rd_done;

  // chip always selected, we_n and oe_n do all the work
  assign ce_n = 1'b0;

  // pop only from idle, same edge latches the head entry
  assign take   = (state == sram_ctrl_pkg::st_idle) && q.pending;
  assign q.take = take;

  always_comb begin
    next_state = state;
    case (state)
      sram_ctrl_pkg::st_idle: begin
        if (q.pending) begin
          if (q.op == sram_ctrl_pkg::op_write) begin
            next_state = sram_ctrl_pkg::st_writing;
          end else begin
            next_state = sram_ctrl_pkg::st_reading;
          end
        end
      end
      // single clock in either access state
      sram_ctrl_pkg::st_reading: next_state = sram_ctrl_pkg::st_idle;
      sram_ctrl_pkg::st_writing: next_state = sram_ctrl_pkg::st_idle;
      default:                   next_state = sram_ctrl_pkg::st_idle;
    endcase
  end

  // FSM and result flags
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= sram_ctrl_pkg::st_idle;
      wr_tail  <= 1'b0;
      rd_done  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      state    <= next_state;
      wr_tail  <= (state == sram_ctrl_pkg::st_writing);
      rd_done  <= (state == sram_ctrl_pkg::st_reading);
      // data was captured half a clock ago, pulse for one cycle
      rd_valid <= rd_done;
    end
  end

  // address and write data held for the whole access
  always_ff @(posedge clk) begin
    if (take) begin
      addr_bus       <= q.addr;
      write_data_reg <= q.data;
    end
  end

  // strobes on the falling edge, half a clock after addr settles
  // they follow the state of the previous rising edge
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      we_n <= 1'b1;
      oe_n <= 1'b1;
    end else begin
      we_n <= (state != sram_ctrl_pkg::st_writing);
      oe_n <= (state != sram_ctrl_pkg::st_reading);
    end
  end

  // sample the bus on the edge that ends the oe_n window
  // oe_n still reads low here, so this fires once per read
  always_ff @(negedge clk) begin
    if (!oe_n) begin
      read_data <= data_bus_io;
    end
  end

  // drive from E to E + 2
  // covers the rising edge of we_n at E + 1.5 with half a clock of hold
  assign bus_drive   = (state == sram_ctrl_pkg::st_writing) || wr_tail;
  assign data_bus_io = bus_drive ? write_data_reg : {data_bits{1'bz}};

  // the chip must never see both strobes active
  strobes_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(!we_n && !oe_n)
  ) else $error("sram_controller: we_n and oe_n low together in %s", state.name());

  // each strobe pulse is exactly one clock wide
  we_n_one_clock: assert property (
    @(posedge clk) disable iff (reset)
    $fell(we_n) |=> $rose(we_n)
  ) else $error("sram_controller: we_n pulse width wrong");

  oe_n_one_clock: assert property (
    @(posedge clk) disable iff (reset)
    $fell(oe_n) |=> $rose(oe_n)
  ) else $error("sram_controller: oe_n pulse width wrong");

  // no contention with the chip output during a read
  no_drive_on_read: assert property (
    @(posedge clk) disable iff (reset)
    !oe_n |-> !bus_drive
  ) else $error("sram_controller: bus driven while oe_n low in %s", state.name());

endmodule

// File: src/sram_req_queue.sv
module sram_req_queue #(
  parameter int addr_bits   = sram_bus_pkg::default_addr_bits,
  parameter int data_bits   = sram_bus_pkg::default_data_bits,
  parameter int queue_depth = sram_bus_pkg::default_queue_depth
) (
  input  logic                 clk,
  input  logic                 reset,
  // caller side, a request is taken when req and ready are both high
  input  logic                 req,
  input  logic                 write_enable,
  input  logic [addr_bits-1:0] addr,
  input  logic [data_bits-1:0] write_data,
  output logic                 ready,
  // controller side
  sram_req_if.queue_side       q
);

  // depth is a power of two, so the pointers wrap on their own
  localparam int ptr_bits = $clog2(queue_depth);
  // count has to reach queue_depth itself
  localparam int cnt_bits = $clog2(queue_depth + 1);

  // entry storage
  sram_ctrl_pkg::sram_op_e op_mem   [queue_depth];
  logic [addr_bits-1:0]    addr_mem [queue_depth];
  logic [data_bits-1:0]    data_mem [queue_depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;

  logic push;
  logic pop;

  // full only when every slot is taken
  // a pop in the same cycle does not open a slot early
  assign ready = (count != cnt_bits'(queue_depth));

  assign push = req && ready;
  assign pop  = q.take;

  // write side, payload only
  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr]   <= write_enable ? sram_ctrl_pkg::op_write
                                       : sram_ctrl_pkg::op_read;
      addr_mem[wr_ptr] <= addr;
      data_mem[wr_ptr] <= write_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry goes straight out, the controller samples it at take
  // pending rises the cycle after the accepting edge
  assign q.pending = (count != '0);
  assign q.op      = op_mem[rd_ptr];
  assign q.addr    = addr_mem[rd_ptr];
  assign q.data    = data_mem[rd_ptr];

  // the controller may only pop an entry that is there
  take_needs_pending: assert property (
    @(posedge clk) disable iff (reset)
    q.take |-> q.pending
  ) else $error("sram_req_queue: take while the queue is empty");

  // occupancy never runs past the buffer size
  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= cnt_bits'(queue_depth)
  ) else $error("sram_req_queue: count %0d over depth", count);

endmodule

// File: src/sram_req_if.sv
// head of the request queue as seen by the SRAM controller
interface sram_req_if #(
  parameter int addr_bits = sram_bus_pkg::default_addr_bits,
  parameter int data_bits = sram_bus_pkg::default_data_bits
);

  // level, head entry holds a valid request
  logic pending;
  // head entry payload, stable while pending is high
  sram_ctrl_pkg::sram_op_e op;
  logic [addr_bits-1:0] addr;
  logic [data_bits-1:0] data;
  // one-cycle pulse from the controller, pops the head
  logic take;

  modport queue_side (
    output pending,
    output op,
    output addr,
    output data,
    input  take
  );

  modport ctrl_side (
    input  pending,
    input  op,
    input  addr,
    input  data,
    output take
  );

endinterface

// File: src/sram_ctrl_pkg.sv
package sram_ctrl_pkg;

  // request opcode as it sits in the queue
  // op_write matches write_enable high on the caller side
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } sram_op_e;

  // access FSM
  // st_idle waits for a queued request, the other two states
  // each last one clock and always fall back to st_idle
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_reading = 2'd1,
    st_writing = 2'd2
  } ctrl_state_e;

endpackage

// File: src/sram_bus_pkg.sv
package sram_bus_pkg;

  // geometry of the external asynchronous SRAM chip
  // a 1M x 16 part, addressed by word
  parameter int default_addr_bits = 20;

  // one word per access, no byte lanes
  parameter int default_data_bits = 16;

  // pending request slots in front of the controller
  // must stay a power of two, 2 or more
  parameter int default_queue_depth = 4;

  // chip timing, in ns
  // read data output delay after oe_n falls, and the time the chip
  // needs to float the bus after oe_n rises.
  // it has to stay at or under half a clock so the bus is free
  // before the controller drives write data again
  parameter int t_output_ns = 4;

endpackage
